/* run_sim.sh */
#!/bin/sh
# Compiles the clock generator with its testbench in Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f vlog.f --top-module tb_clkgen -o tb_clkgen
./obj_dir/tb_clkgen > sim.log
cat sim.log

# The run passes only if the testbench printed its pass line
grep -qx "NO ERRORS" sim.log
echo "Simulation passed"

/* verification/tb_clkgen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen;

	localparam int PERIOD = 20;
	localparam int LEN_RESET = 10; // Test lengths in clock cycles, worst case
	localparam int LEN_REGS = 700;
	localparam int LEN_NTSC = 100;
	localparam int LEN_PAL = 120;
	localparam int LEN_COUNT = 500;
	localparam int LEN_IRQ = 300;
	localparam int LEN_STOP = 150;
	localparam int TEST_CYCLES = LEN_RESET + LEN_REGS + LEN_NTSC + LEN_PAL + LEN_COUNT +
		LEN_IRQ + LEN_STOP;
	localparam int WATCHDOG_NS = TEST_CYCLES * PERIOD * 3 / 2;
	localparam int IRQ_LIMIT = 200;

	logic clk = 1'b0;
	logic rst_n;
	logic [reg_pkg::ADDR_W-1:0] awaddr;
	logic awvalid;
	logic awready;
	logic [reg_pkg::DATA_W-1:0] wdata;
	logic [reg_pkg::STRB_W-1:0] wstrb;
	logic wvalid;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;
	logic [reg_pkg::ADDR_W-1:0] araddr;
	logic arvalid;
	logic arready;
	logic [reg_pkg::DATA_W-1:0] rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;
	logic phi1;
	logic phi2;
	logic m2;
	logic irq;

	int errors = 0;
	logic [31:0] rng = 32'd9;
	int rises = 0; // phi1 rising edges seen so far
	logic rose_now = 1'b0;
	logic phi1_prev = 1'b0;
	int wr_mark; // Rises up to and including the last write handshake cycle
	int rd_mark; // Rises before the last read handshake cycle
	logic [31:0] ctrl_shadow = '0;
	logic [31:0] compare_shadow = '0;

	clkgen_top dut0 (.*);

	always #(PERIOD / 2) clk = ~clk;

	always @(negedge clk) begin
		rose_now = phi1 && !phi1_prev;
		phi1_prev = phi1;
		if (rose_now) rises = rises + 1;
	end

	function automatic logic [31:0] next_rand();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	function automatic logic [31:0] apply_strobes(input logic [31:0] old_val,
			input logic [31:0] new_val, input logic [3:0] strb);
		logic [31:0] mask;
		mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
		return (old_val & ~mask) | (new_val & mask);
	endfunction

	// Outputs are read a little after the falling edge, once the edge monitor has run
	task automatic wait_sample();
		@(negedge clk);
		#1;
	endtask

	task automatic check_word(input logic [reg_pkg::DATA_W-1:0] actual,
			input logic [reg_pkg::DATA_W-1:0] expected, input string what);
		if (actual !== expected) begin
			errors++;
			$display("ERR %0t: %s is %h, expected %h", $time, what, actual, expected);
		end
	endtask

	task automatic check_phase(input int actual, input int expected, input string what);
		if (actual != expected) begin
			errors++;
			$display("ERR %0t: %s is %0d, expected %0d", $time, what, actual, expected);
		end
	endtask

	task automatic axi_write(input logic [reg_pkg::ADDR_W-1:0] addr, input logic [31:0] data,
			input logic [3:0] strb, output logic [1:0] resp);
		int stall;
		stall = int'(next_rand() % 32'd4); // Cycles that bready stays low
		@(posedge clk);
		awaddr <= addr;
		wdata <= data;
		wstrb <= strb;
		awvalid <= 1'b1;
		wvalid <= 1'b1;
		do wait_sample(); while (!awready);
		wr_mark = rises;
		@(posedge clk);
		awvalid <= 1'b0;
		wvalid <= 1'b0;
		repeat (stall) @(posedge clk);
		bready <= 1'b1;
		do wait_sample(); while (!bvalid);
		resp = bresp;
		@(posedge clk);
		bready <= 1'b0;
	endtask

	task automatic axi_read(input logic [reg_pkg::ADDR_W-1:0] addr, output logic [31:0] data,
			output logic [1:0] resp);
		int stall;
		stall = int'(next_rand() % 32'd4);
		@(posedge clk);
		araddr <= addr;
		arvalid <= 1'b1;
		do wait_sample(); while (!arready);
		rd_mark = rises - (rose_now ? 1 : 0); // COUNT is sampled before this cycle's increment
		@(posedge clk);
		arvalid <= 1'b0;
		repeat (stall) @(posedge clk);
		rready <= 1'b1;
		do wait_sample(); while (!rvalid);
		data = rdata;
		resp = rresp;
		@(posedge clk);
		rready <= 1'b0;
	endtask

	task automatic write_ok(input logic [reg_pkg::ADDR_W-1:0] addr, input logic [31:0] data,
			input logic [3:0] strb, input string what);
		logic [1:0] resp;
		axi_write(addr, data, strb, resp);
		check_word({30'b0, resp}, {30'b0, reg_pkg::RESP_OKAY}, {what, " write response"});
	endtask

	task automatic expect_read(input logic [reg_pkg::ADDR_W-1:0] addr,
			input logic [31:0] expected, input string what);
		logic [31:0] data;
		logic [1:0] resp;
		axi_read(addr, data, resp);
		check_word({30'b0, resp}, {30'b0, reg_pkg::RESP_OKAY}, {what, " read response"});
		check_word(data, expected, what);
	endtask

	task automatic wait_rise();
		do wait_sample(); while (!rose_now);
	endtask

	// Counts window lengths over whole periods, starting at tick 0
	task automatic measure_phases(input int div, input int periods);
		int hi1;
		int hi_m2;
		int start;
		hi1 = 0;
		hi_m2 = 0;
		wait_rise();
		start = rises;
		repeat (div * periods) begin
			if (phi1) hi1++;
			if (m2) hi_m2++;
			check_word({31'b0, phi2}, {31'b0, ~phi1}, "phi2 against inverted phi1");
			wait_sample();
		end
		check_phase(hi1, periods * div / 2, "phi1 high ticks");
		check_phase(hi_m2, periods * (div / 2 + 1), "m2 high ticks");
		check_phase(rises - start, periods, "phi1 rises in window");
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: run stopped after %0d ns with %0d errors", WATCHDOG_NS, errors);
		$display("ERRORS FOUND");
		$finish;
	end

	initial begin
		logic [31:0] r;
		logic [31:0] data;
		logic [31:0] rd;
		logic [31:0] c1;
		logic [31:0] c2;
		logic [31:0] cmp;
		logic [3:0] strb;
		logic [reg_pkg::ADDR_W-1:0] addr;
		logic [1:0] resp;
		int mark;
		int n;
		int waited;
		rst_n <= 1'b0;
		awaddr <= '0;
		awvalid <= 1'b0;
		wdata <= '0;
		wstrb <= '0;
		wvalid <= 1'b0;
		bready <= 1'b0;
		araddr <= '0;
		arvalid <= 1'b0;
		rready <= 1'b0;
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		wait_sample();
		check_word({23'b0, awready, wready, bvalid, arready, rvalid, phi1, phi2, m2, irq}, 32'h0,
			"handshake and clock outputs after reset");
		expect_read(reg_pkg::ADDR_CTRL, 32'h0, "CTRL after reset");
		expect_read(reg_pkg::ADDR_COMPARE, 32'h0, "COMPARE after reset");
		expect_read(reg_pkg::ADDR_COUNT, 32'h0, "COUNT after reset");
		expect_read(reg_pkg::ADDR_STATUS, 32'h0, "STATUS after reset");

		for (int i = 0; i < 12; i++) begin
			data = next_rand();
			r = next_rand();
			strb = r[3:0];
			write_ok(reg_pkg::ADDR_CTRL, data, strb, "CTRL");
			ctrl_shadow = apply_strobes(ctrl_shadow, data, strb) & 32'h7;
			expect_read(reg_pkg::ADDR_CTRL, ctrl_shadow, "CTRL");
			write_ok(reg_pkg::ADDR_COMPARE, r, r[7:4], "COMPARE");
			compare_shadow = apply_strobes(compare_shadow, r, r[7:4]) & 32'hFFFF;
			expect_read(reg_pkg::ADDR_COMPARE, compare_shadow, "COMPARE");
			addr = {r[11:10], (r[9:8] == 2'b00) ? 2'b01 : r[9:8]}; // Off the word grid
			axi_write(addr, data, 4'hF, resp);
			check_word({30'b0, resp}, {30'b0, reg_pkg::RESP_SLVERR}, "unmapped write response");
			axi_read(addr, rd, resp);
			check_word({30'b0, resp}, {30'b0, reg_pkg::RESP_SLVERR}, "unmapped read response");
		end
		expect_read(reg_pkg::ADDR_CTRL, ctrl_shadow, "CTRL after unmapped writes");
		expect_read(reg_pkg::ADDR_COMPARE, compare_shadow, "COMPARE after unmapped writes");

		write_ok(reg_pkg::ADDR_CTRL, 32'h1, 4'hF, "CTRL enable NTSC");
		measure_phases(clk_pkg::DIV_NTSC, 4);

		write_ok(reg_pkg::ADDR_CTRL, 32'h3, 4'hF, "CTRL enable PAL");
		wait_rise(); // The period that was running at the switch
		measure_phases(clk_pkg::DIV_PAL, 4);

		for (int i = 0; i < 4; i++) begin
			axi_read(reg_pkg::ADDR_COUNT, c1, resp);
			mark = rd_mark;
			n = int'(next_rand() % 32'd64);
			repeat (n) @(posedge clk);
			axi_read(reg_pkg::ADDR_COUNT, c2, resp);
			check_word((c2 - c1) & 32'hFFFF, 32'(rd_mark - mark), "COUNT step over phi1 rises");
			write_ok(reg_pkg::ADDR_COUNT, next_rand(), 4'hF, "COUNT");
			mark = wr_mark;
			repeat (n / 4) @(posedge clk);
			axi_read(reg_pkg::ADDR_COUNT, c2, resp);
			check_word(c2, 32'(rd_mark - mark), "COUNT after clear");
		end

		axi_read(reg_pkg::ADDR_COUNT, c1, resp);
		cmp = (c1 + 32'd4 + (next_rand() % 32'd3)) & 32'hFFFF; // A few CPU cycles ahead
		write_ok(reg_pkg::ADDR_COMPARE, cmp, 4'hF, "COMPARE");
		write_ok(reg_pkg::ADDR_STATUS, 32'h1, 4'h1, "STATUS"); // Drop any stale match
		write_ok(reg_pkg::ADDR_CTRL, 32'h7, 4'hF, "CTRL with irq_en");
		wait_sample();
		check_word({31'b0, irq}, 32'h0, "irq before the match");
		waited = 0;
		while (!irq && waited < IRQ_LIMIT) begin
			wait_sample();
			waited++;
		end
		if (!irq) begin
			errors++;
			$display("irq never rose within %0d cycles of arming the compare", IRQ_LIMIT);
		end
		expect_read(reg_pkg::ADDR_COUNT, cmp, "COUNT at irq");
		expect_read(reg_pkg::ADDR_STATUS, 32'h1, "STATUS with irq pending");

		write_ok(reg_pkg::ADDR_CTRL, 32'h4, 4'hF, "CTRL disable"); // The pending flag and irq_en stay set
		axi_read(reg_pkg::ADDR_COUNT, c1, resp);
		n = 10 + int'(next_rand() % 32'd32);
		repeat (n) begin
			wait_sample();
			check_word({28'b0, phi1, phi2, m2, irq}, 32'h0, "clock outputs while disabled");
		end
		expect_read(reg_pkg::ADDR_COUNT, c1, "COUNT while disabled");
		expect_read(reg_pkg::ADDR_STATUS, 32'h1, "STATUS while disabled");

		write_ok(reg_pkg::ADDR_CTRL, 32'h7, 4'hF, "CTRL enable again");
		wait_sample();
		check_word({31'b0, irq}, 32'h1, "irq once enabled again");
		write_ok(reg_pkg::ADDR_STATUS, 32'h1, 4'h1, "STATUS clear");
		wait_sample();
		check_word({31'b0, irq}, 32'h0, "irq after STATUS clear");
		expect_read(reg_pkg::ADDR_STATUS, 32'h0, "STATUS after clear");

		$display("Run complete with %0d errors", errors);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* verilog/clk_ctrl_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface clk_ctrl_if;

	reg_pkg::ctrl_word_t ctrl;
	logic [clk_pkg::CNT_W-1:0] compare;
	logic count_clear; // One cycle, on a COUNT write handshake
	logic irq_clear; // One cycle, on a STATUS write with bit 0 set

	logic [clk_pkg::CNT_W-1:0] count;
	logic irq_pending;

	modport regs (
		output ctrl,
		output compare,
		output count_clear,
		output irq_clear,
		input count,
		input irq_pending
	);

	modport divider (
		input ctrl
	);

	modport timer (
		input ctrl,
		input compare,
		input count_clear,
		input irq_clear,
		output count,
		output irq_pending
	);

endinterface

`default_nettype wire

/* verilog/clk_divider.sv */
`timescale 1ns/1ps
`default_nettype none

module clk_divider (
	input logic clk,
	input logic rst_n,
	clk_ctrl_if.divider cfg,
	output logic phi1,
	output logic phi2,
	output logic m2,
	output logic cycle_start
);

	logic [clk_pkg::TICK_W-1:0] tick;
	logic pal_q; // Mode of the running period
	logic run_q; // Enable as seen in the previous cycle
	logic enable;
	logic mode;
	logic [clk_pkg::TICK_W-1:0] last_tick;
	logic [clk_pkg::TICK_W-1:0] half_tick;
	logic [clk_pkg::TICK_W-1:0] m2_tick;

	assign enable = cfg.ctrl.f.enable;

	// The first period after enabling takes the mode straight from CTRL
	assign mode = run_q ? pal_q : cfg.ctrl.f.pal_mode;

	assign last_tick = mode ? clk_pkg::PAL_LAST : clk_pkg::NTSC_LAST;
	assign half_tick = mode ? clk_pkg::PAL_HALF : clk_pkg::NTSC_HALF;
	assign m2_tick = mode ? clk_pkg::PAL_M2_ON : clk_pkg::NTSC_M2_ON;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			tick <= '0;
			pal_q <= 1'b0;
			run_q <= 1'b0;
		end else begin
			run_q <= enable;
			if (!enable) begin
				tick <= '0;
			end else if (tick == last_tick) begin
				tick <= '0;
				pal_q <= cfg.ctrl.f.pal_mode; // New mode applies from the next period
			end else begin
				tick <= tick + 1'b1;
				pal_q <= mode;
			end
		end
	end

	// Phase windows come straight from the registered tick
	assign phi1 = enable && (tick < half_tick);
	assign phi2 = enable && (tick >= half_tick);
	assign m2 = enable && (tick >= m2_tick);
	assign cycle_start = enable && (tick == '0);

endmodule

`default_nettype wire

/* verilog/clk_pkg.sv */
`default_nettype none

package clk_pkg;

	localparam int DIV_NTSC = 12; // Master ticks per CPU cycle in NTSC mode
	localparam int DIV_PAL = 16; // Master ticks per CPU cycle in PAL mode

	localparam int TICK_W = 4; // Holds 0 to 15
	localparam int CNT_W = 16;

	// Last tick of a period, where the counter wraps
	localparam logic [TICK_W-1:0] NTSC_LAST = TICK_W'(DIV_NTSC - 1);
	localparam logic [TICK_W-1:0] PAL_LAST = TICK_W'(DIV_PAL - 1);

	// First tick of the phi2 half
	localparam logic [TICK_W-1:0] NTSC_HALF = TICK_W'(DIV_NTSC / 2);
	localparam logic [TICK_W-1:0] PAL_HALF = TICK_W'(DIV_PAL / 2);

	// The m2 strobe opens one tick ahead of phi2
	localparam logic [TICK_W-1:0] NTSC_M2_ON = TICK_W'(DIV_NTSC / 2 - 1);
	localparam logic [TICK_W-1:0] PAL_M2_ON = TICK_W'(DIV_PAL / 2 - 1);

endpackage

`default_nettype wire

/* verilog/clk_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module clk_regs (
	input logic clk,
	input logic rst_n,
	input logic [reg_pkg::ADDR_W-1:0] awaddr,
	input logic awvalid,
	output logic awready,
	input logic [reg_pkg::DATA_W-1:0] wdata,
	input logic [reg_pkg::STRB_W-1:0] wstrb,
	input logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input logic bready,
	input logic [reg_pkg::ADDR_W-1:0] araddr,
	input logic arvalid,
	output logic arready,
	output logic [reg_pkg::DATA_W-1:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input logic rready,
	clk_ctrl_if.regs cfg
);

	localparam int PAD_W = reg_pkg::DATA_W - clk_pkg::CNT_W;

	reg_pkg::ctrl_word_t ctrl_q;
	reg_pkg::ctrl_word_t ctrl_next;
	logic [clk_pkg::CNT_W-1:0] compare_q;
	logic [reg_pkg::DATA_W-1:0] compare_merged;
	logic wr_fire;
	logic rd_fire;
	logic wr_ok;
	logic rd_ok;
	logic [reg_pkg::DATA_W-1:0] rd_word;

	function automatic logic [reg_pkg::DATA_W-1:0] merge_strb(
		input logic [reg_pkg::DATA_W-1:0] old_val,
		input logic [reg_pkg::DATA_W-1:0] new_val,
		input logic [reg_pkg::STRB_W-1:0] strb
	);
		logic [reg_pkg::DATA_W-1:0] res;
		res = old_val;
		for (int i = 0; i < reg_pkg::STRB_W; i++) begin
			if (strb[i]) begin
				res[8*i +: 8] = new_val[8*i +: 8];
			end
		end
		return res;
	endfunction

	// A pending response blocks the next handshake
	assign wr_fire = awvalid && wvalid && !bvalid;
	assign rd_fire = arvalid && !rvalid;
	assign awready = wr_fire;
	assign wready = wr_fire;
	assign arready = rd_fire;

	assign wr_ok = (awaddr == reg_pkg::ADDR_CTRL) || (awaddr == reg_pkg::ADDR_COMPARE) ||
		(awaddr == reg_pkg::ADDR_COUNT) || (awaddr == reg_pkg::ADDR_STATUS);

	always_comb begin
		ctrl_next.raw = merge_strb(ctrl_q.raw, wdata, wstrb);
		ctrl_next.f.rsvd = '0;
		compare_merged = merge_strb({{PAD_W{1'b0}}, compare_q}, wdata, wstrb);
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ctrl_q <= '0;
			compare_q <= '0;
		end else if (wr_fire) begin
			if (awaddr == reg_pkg::ADDR_CTRL) begin
				ctrl_q <= ctrl_next;
			end
			if (awaddr == reg_pkg::ADDR_COMPARE) begin
				compare_q <= compare_merged[clk_pkg::CNT_W-1:0];
			end
		end
	end

	// Clear pulses act at the end of the handshake cycle
	assign cfg.count_clear = wr_fire && (awaddr == reg_pkg::ADDR_COUNT);
	assign cfg.irq_clear = wr_fire && (awaddr == reg_pkg::ADDR_STATUS) && wstrb[0] && wdata[0];
	assign cfg.ctrl = ctrl_q;
	assign cfg.compare = compare_q;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			bvalid <= 1'b0;
			bresp <= reg_pkg::RESP_OKAY;
		end else if (wr_fire) begin
			bvalid <= 1'b1;
			bresp <= wr_ok ? reg_pkg::RESP_OKAY : reg_pkg::RESP_SLVERR;
		end else if (bready) begin
			bvalid <= 1'b0;
		end
	end

	always_comb begin
		rd_word = '0;
		rd_ok = 1'b1;
		case (araddr)
			reg_pkg::ADDR_CTRL: rd_word = ctrl_q.raw;
			reg_pkg::ADDR_COMPARE: rd_word = {{PAD_W{1'b0}}, compare_q};
			reg_pkg::ADDR_COUNT: rd_word = {{PAD_W{1'b0}}, cfg.count};
			reg_pkg::ADDR_STATUS: rd_word = {{(reg_pkg::DATA_W-1){1'b0}}, cfg.irq_pending};
			default: rd_ok = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rvalid <= 1'b0;
			rresp <= reg_pkg::RESP_OKAY;
			rdata <= '0;
		end else if (rd_fire) begin
			rvalid <= 1'b1;
			rresp <= rd_ok ? reg_pkg::RESP_OKAY : reg_pkg::RESP_SLVERR;
			rdata <= rd_word; // Sampled in the address handshake cycle
		end else if (rready) begin
			rvalid <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* verilog/clkgen_top.sv */
`timescale 1ns/1ps
`default_nettype none

module clkgen_top (
	input logic clk,
	input logic rst_n,
	input logic [reg_pkg::ADDR_W-1:0] awaddr,
	input logic awvalid,
	output logic awready,
	input logic [reg_pkg::DATA_W-1:0] wdata,
	input logic [reg_pkg::STRB_W-1:0] wstrb,
	input logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input logic bready,
	input logic [reg_pkg::ADDR_W-1:0] araddr,
	input logic arvalid,
	output logic arready,
	output logic [reg_pkg::DATA_W-1:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input logic rready,
	output logic phi1,
	output logic phi2,
	output logic m2,
	output logic irq
);

	logic cycle_start;

	clk_ctrl_if cfg ();

	clk_regs regs0 (
		.clk(clk),
		.rst_n(rst_n),
		.awaddr(awaddr),
		.awvalid(awvalid),
		.awready(awready),
		.wdata(wdata),
		.wstrb(wstrb),
		.wvalid(wvalid),
		.wready(wready),
		.bresp(bresp),
		.bvalid(bvalid),
		.bready(bready),
		.araddr(araddr),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rresp(rresp),
		.rvalid(rvalid),
		.rready(rready),
		.cfg(cfg.regs)
	);

	clk_divider div0 (
		.clk(clk),
		.rst_n(rst_n),
		.cfg(cfg.divider),
		.phi1(phi1),
		.phi2(phi2),
		.m2(m2),
		.cycle_start(cycle_start)
	);

	cycle_timer timer0 (
		.clk(clk),
		.rst_n(rst_n),
		.cfg(cfg.timer),
		.cycle_start(cycle_start)
	);

	// Interrupt leaves the block only while enabled in CTRL
	assign irq = cfg.irq_pending && cfg.ctrl.f.irq_en && cfg.ctrl.f.enable;

endmodule

`default_nettype wire

/* verilog/cycle_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module cycle_timer (
	input logic clk,
	input logic rst_n,
	clk_ctrl_if.timer cfg,
	input logic cycle_start
);

	logic [clk_pkg::CNT_W-1:0] count_q;
	logic [clk_pkg::CNT_W-1:0] count_inc;
	logic pending_q;
	logic step;
	logic hit;

	assign step = cycle_start && cfg.ctrl.f.enable && !cfg.count_clear;
	assign count_inc = count_q + 1'b1; // Wraps at 16 bits

	// Match is judged on the value the increment is about to produce
	assign hit = step && (count_inc == cfg.compare);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			count_q <= '0;
		end else if (cfg.count_clear) begin
			count_q <= '0;
		end else if (step) begin
			count_q <= count_inc;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pending_q <= 1'b0;
		end else if (hit) begin
			pending_q <= 1'b1; // A fresh match wins over a clear in the same cycle
		end else if (cfg.irq_clear) begin
			pending_q <= 1'b0;
		end
	end

	assign cfg.count = count_q;
	assign cfg.irq_pending = pending_q;

endmodule

`default_nettype wire

/* verilog/reg_pkg.sv */
`default_nettype none

package reg_pkg;

	localparam int ADDR_W = 4;
	localparam int DATA_W = 32;
	localparam int STRB_W = DATA_W / 8;

	localparam logic [ADDR_W-1:0] ADDR_CTRL = 4'h0;
	localparam logic [ADDR_W-1:0] ADDR_COMPARE = 4'h4;
	localparam logic [ADDR_W-1:0] ADDR_COUNT = 4'h8; // Read the cycle count, write to clear it
	localparam logic [ADDR_W-1:0] ADDR_STATUS = 4'hC; // Bit 0 is irq pending, write 1 to clear

	localparam logic [1:0] RESP_OKAY = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	typedef struct packed {
		logic [DATA_W-4:0] rsvd; // Reads back as zero
		logic irq_en;
		logic pal_mode;
		logic enable;
	} ctrl_fields_t;

	// Bus side sees the raw word, timing side sees the fields
	typedef union packed {
		logic [DATA_W-1:0] raw;
		ctrl_fields_t f;
	} ctrl_word_t;

endpackage

`default_nettype wire

/* vlog.f */
verilog/clk_pkg.sv
verilog/reg_pkg.sv
verilog/clk_ctrl_if.sv
verilog/clk_divider.sv
verilog/cycle_timer.sv
verilog/clk_regs.sv
verilog/clkgen_top.sv
verification/tb_clkgen.sv
